/* logic/clic_ctrl.sv */
// interrupt take, tail chain and return decision
`timescale 1ns/1ns

module clic_ctrl
  import clic_pkg::*;
#(
  parameter int VecSize = 8
) (
  input  winner_t            win,
  input  prio_t              thresh,
  input  imem_addr_t         pc_in,
  input  stack_entry_t       top,
  output int_action_t        action,
  output stack_entry_t       push_data,
  output logic               thresh_we,
  output prio_t              thresh_data,
  output logic [VecSize-1:0] clear_pend,
  output imem_addr_t         int_addr,
  output pc_interrupt_mux_t  pc_interrupt_sel,
  output logic               interrupt_out
);

  localparam int IdxWidth = (VecSize > 1) ? $clog2(VecSize) : 1;
  typedef logic [IdxWidth-1:0] idx_t;

  idx_t       sel;
  logic       is_ret;
  imem_addr_t vec_addr;

  assign sel      = idx_t'(win.index);
  assign is_ret   = (pc_in == RetMarker);
  // handler word address to byte address
  assign vec_addr = {win.vec, 2'b00};

  // pc and old threshold are stacked on take and restored on return
  assign push_data = '{addr: pc_in, prio: thresh};

  always_comb begin
    action           = ACT_NONE;
    thresh_we        = 1'b0;
    thresh_data      = '0;
    clear_pend       = '0;
    int_addr         = pc_in;
    pc_interrupt_sel = PC_NORMAL;
    interrupt_out    = 1'b0;
    if (win.valid && (win.prio > thresh)) begin
      // preempt and raise the threshold to the new level
      action           = ACT_TAKE;
      thresh_we        = 1'b1;
      thresh_data      = win.prio;
      clear_pend[sel]  = 1'b1;
      int_addr         = vec_addr;
      pc_interrupt_sel = PC_INTERRUPT;
      interrupt_out    = 1'b1;
    end else if (is_ret && win.valid) begin
      // tail chain keeps the stack and the threshold
      action           = ACT_TAIL;
      clear_pend[sel]  = 1'b1;
      int_addr         = vec_addr;
      pc_interrupt_sel = PC_INTERRUPT;
      interrupt_out    = 1'b1;
    end else if (is_ret) begin
      action           = ACT_RETURN;
      thresh_we        = 1'b1;
      thresh_data      = top.prio;
      int_addr         = top.addr;
      pc_interrupt_sel = PC_INTERRUPT;
    end
  end

  // at most one acknowledge per cycle
  always_comb begin
    assert ($onehot0(clear_pend))
      else $error("more than one pend clear active");
  end

endmodule

/* logic/clic_pkg.sv */
// interrupt controller shared definitions
package clic_pkg;

  typedef logic [31:0] word;
  typedef logic [11:0] csr_addr_t;

  localparam int PrioWidth = 3;
  typedef logic [PrioWidth-1:0] prio_t;

  localparam int IMemAddrWidth = 16;
  typedef logic [IMemAddrWidth-1:0] imem_addr_t;
  // word address, byte offset bits dropped
  typedef logic [IMemAddrWidth-3:0] vec_store_t;

  // pc value the core presents on interrupt return
  localparam imem_addr_t RetMarker = '1;

  // csr address map, both bases aligned to 64
  localparam csr_addr_t MIntThreshAddr = 12'h347;
  localparam csr_addr_t VecCsrBase = 12'hb00;
  localparam csr_addr_t EntryCsrBase = 12'hb40;
  // offset bits within one bank, limits the number of vectors to 64
  localparam int VecIdxWidth = 6;

  // riscv funct3 encodings
  typedef enum logic [2:0] {
    CSR_RW  = 3'b001,
    CSR_RS  = 3'b010,
    CSR_RC  = 3'b011,
    CSR_RWI = 3'b101,
    CSR_RSI = 3'b110,
    CSR_RCI = 3'b111
  } csr_op_t;

  typedef enum logic {
    PC_NORMAL,
    PC_INTERRUPT
  } pc_interrupt_mux_t;

  typedef enum logic [1:0] {
    ACT_NONE,
    ACT_TAKE,
    ACT_TAIL,
    ACT_RETURN
  } int_action_t;

  typedef struct packed {
    prio_t prio;
    logic  enabled;
    // lsb, so an immediate can reach it
    logic  pended;
  } entry_t;

  typedef struct packed {
    csr_op_t op;
    word     operand;
  } csr_wr_t;

  typedef struct packed {
    logic       active;
    prio_t      prio;
    vec_store_t vec;
  } slot_req_t;

  typedef struct packed {
    logic                   valid;
    prio_t                  prio;
    vec_store_t             vec;
    logic [VecIdxWidth-1:0] index;
  } winner_t;

  typedef struct packed {
    imem_addr_t addr;
    prio_t      prio;
  } stack_entry_t;

endpackage

/* logic/csr_access.sv */
// csr address decode and readback
`timescale 1ns/1ns

module csr_access
  import clic_pkg::*;
#(
  parameter int VecSize = 8
) (
  input  logic               csr_enable,
  input  csr_addr_t          csr_addr,
  input  csr_op_t            csr_op,
  input  logic [4:0]         rs1_zimm,
  input  word                rs1_data,
  input  word                thresh_val,
  input  word                vec_val   [VecSize],
  input  word                entry_val [VecSize],
  output csr_wr_t            wr,
  output logic               thresh_we,
  output logic [VecSize-1:0] vec_we,
  output logic [VecSize-1:0] entry_we,
  output word                csr_out
);

  logic                   thresh_hit;
  logic                   vec_hit;
  logic                   entry_hit;
  logic [VecIdxWidth-1:0] offset;
  word                    operand;

  // bank select on the upper bits, slot on the low bits
  assign thresh_hit = (csr_addr == MIntThreshAddr);
  assign vec_hit    = (csr_addr[11:VecIdxWidth] == VecCsrBase[11:VecIdxWidth]);
  assign entry_hit  = (csr_addr[11:VecIdxWidth] == EntryCsrBase[11:VecIdxWidth]);
  assign offset     = csr_addr[VecIdxWidth-1:0];

  always_comb begin
    case (csr_op)
      CSR_RW, CSR_RS, CSR_RC: operand = rs1_data;
      default:                operand = word'(rs1_zimm);
    endcase
  end

  assign wr = '{op: csr_op, operand: operand};

  always_comb begin
    thresh_we = csr_enable && thresh_hit;
    for (int k = 0; k < VecSize; k++) begin
      vec_we[k]   = csr_enable && vec_hit && (offset == VecIdxWidth'(k));
      entry_we[k] = csr_enable && entry_hit && (offset == VecIdxWidth'(k));
    end
  end

  // readback, unmapped addresses give zero
  always_comb begin
    csr_out = '0;
    if (thresh_hit) begin
      csr_out = thresh_val;
    end
    for (int k = 0; k < VecSize; k++) begin
      if (vec_hit && (offset == VecIdxWidth'(k))) begin
        csr_out = vec_val[k];
      end
      if (entry_hit && (offset == VecIdxWidth'(k))) begin
        csr_out = entry_val[k];
      end
    end
  end

  // address map must keep every register distinct
  always_comb begin
    assert ($onehot0({thresh_we, vec_we, entry_we}))
      else $error("more than one csr write strobe active");
  end

endmodule

/* logic/csr_reg.sv */
// single control and status register
`timescale 1ns/1ns

module csr_reg
  import clic_pkg::*;
#(
  parameter int Width = 8
) (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             we,
  input  csr_wr_t          wr,
  input  logic             ext_we,
  input  logic [Width-1:0] ext_data,
  output logic [Width-1:0] data,
  output word              value
);

  logic [Width-1:0] operand;

  // only the bits this register holds
  assign operand = wr.operand[Width-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data <= '0;
    end else if (ext_we) begin
      // controller update has priority over software
      data <= ext_data;
    end else if (we) begin
      case (wr.op)
        CSR_RW, CSR_RWI: data <= operand;
        CSR_RS, CSR_RSI: data <= data | operand;
        CSR_RC, CSR_RCI: data <= data & ~operand;
        default:         data <= data;
      endcase
    end
  end

  assign value = word'(data);

endmodule

/* logic/n_clic.sv */
// nested vectored interrupt controller top
`timescale 1ns/1ns

module n_clic
  import clic_pkg::*;
#(
  parameter int VecSize    = 8,
  parameter int StackDepth = 8
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              csr_enable,
  input  csr_addr_t         csr_addr,
  input  csr_op_t           csr_op,
  input  logic [4:0]        rs1_zimm,
  input  word               rs1_data,
  input  imem_addr_t        pc_in,
  output word               csr_out,
  output imem_addr_t        int_addr,
  output pc_interrupt_mux_t pc_interrupt_sel,
  output prio_t             level_out,
  output logic              interrupt_out
);

  csr_wr_t            wr;
  logic               csr_thresh_we;
  logic [VecSize-1:0] vec_we;
  logic [VecSize-1:0] entry_we;
  word                thresh_val;
  word                vec_val   [VecSize];
  word                entry_val [VecSize];

  prio_t              thresh;
  logic               hw_thresh_we;
  prio_t              hw_thresh_data;
  logic [VecSize-1:0] clear_pend;

  slot_req_t          req [VecSize];
  winner_t            win;
  int_action_t        action;
  stack_entry_t       push_data;
  stack_entry_t       top;

  csr_access #(
    .VecSize(VecSize)
  ) u_csr_access (
    .csr_enable,
    .csr_addr,
    .csr_op,
    .rs1_zimm,
    .rs1_data,
    .thresh_val,
    .vec_val,
    .entry_val,
    .wr,
    .thresh_we(csr_thresh_we),
    .vec_we,
    .entry_we,
    .csr_out
  );

  csr_reg #(
    .Width(PrioWidth)
  ) u_thresh (
    .clk,
    .arst_n,
    .we      (csr_thresh_we),
    .wr,
    .ext_we  (hw_thresh_we),
    .ext_data(hw_thresh_data),
    .data    (thresh),
    .value   (thresh_val)
  );

  for (genvar k = 0; k < VecSize; k++) begin : gen_slot
    vector_slot u_slot (
      .clk,
      .arst_n,
      .wr,
      .vec_we    (vec_we[k]),
      .entry_we  (entry_we[k]),
      .clear_pend(clear_pend[k]),
      .req       (req[k]),
      .vec_val   (vec_val[k]),
      .entry_val (entry_val[k])
    );
  end

  prio_select #(
    .VecSize(VecSize)
  ) u_prio_select (
    .req,
    .thresh,
    .win
  );

  ret_stack #(
    .StackDepth(StackDepth)
  ) u_ret_stack (
    .clk,
    .arst_n,
    .action,
    .push_data,
    .top,
    .level(level_out)
  );

  clic_ctrl #(
    .VecSize(VecSize)
  ) u_clic_ctrl (
    .win,
    .thresh,
    .pc_in,
    .top,
    .action,
    .push_data,
    .thresh_we  (hw_thresh_we),
    .thresh_data(hw_thresh_data),
    .clear_pend,
    .int_addr,
    .pc_interrupt_sel,
    .interrupt_out
  );

endmodule

/* logic/prio_select.sv */
// highest priority pending vector
`timescale 1ns/1ns

module prio_select
  import clic_pkg::*;
#(
  parameter int VecSize = 8
) (
  input  slot_req_t req [VecSize],
  input  prio_t     thresh,
  output winner_t   win
);

  localparam int IdxWidth = (VecSize > 1) ? $clog2(VecSize) : 1;
  typedef logic [IdxWidth-1:0] idx_t;

  prio_t      max_prio;
  vec_store_t max_vec;
  idx_t       max_idx;
  logic       found;

  // running maximum seeded with the threshold
  // >= lets a later slot win a tie
  always_comb begin
    max_prio = thresh;
    max_vec  = '0;
    max_idx  = '0;
    found    = 1'b0;
    for (int k = 0; k < VecSize; k++) begin
      if (req[k].active && (req[k].prio >= max_prio)) begin
        max_prio = req[k].prio;
        max_vec  = req[k].vec;
        max_idx  = idx_t'(k);
        found    = 1'b1;
      end
    end
  end

  assign win = '{
    valid: found,
    prio:  max_prio,
    vec:   max_vec,
    index: VecIdxWidth'(max_idx)
  };

endmodule

/* logic/ret_stack.sv */
// return pc and threshold stack
`timescale 1ns/1ns

module ret_stack
  import clic_pkg::*;
#(
  parameter int StackDepth = 8
) (
  input  logic         clk,
  input  logic         arst_n,
  input  int_action_t  action,
  input  stack_entry_t push_data,
  output stack_entry_t top,
  output prio_t        level
);

  localparam int CntWidth = $clog2(StackDepth + 1);
  localparam int PtrWidth = (StackDepth > 1) ? $clog2(StackDepth) : 1;

  stack_entry_t          mem [StackDepth];
  logic [CntWidth-1:0]   count;
  logic [PtrWidth-1:0]   wr_ptr;
  logic [PtrWidth-1:0]   top_ptr;

  assign wr_ptr  = PtrWidth'(count);
  assign top_ptr = PtrWidth'(count - 1'b1);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else begin
      case (action)
        ACT_TAKE:   count <= count + 1'b1;
        ACT_RETURN: count <= count - 1'b1;
        default:    count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (action == ACT_TAKE) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // empty stack shows zero
  assign top   = (count != '0) ? mem[top_ptr] : '0;
  assign level = prio_t'(count);

  a_no_push_full: assert property (
    @(posedge clk) disable iff (!arst_n) (action == ACT_TAKE) |-> (count < StackDepth)
  ) else $error("interrupt taken with return stack full");

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!arst_n) (action == ACT_RETURN) |-> (count != '0)
  ) else $error("interrupt return with empty stack");

endmodule

/* logic/vector_slot.sv */
// one interrupt vector with its entry
`timescale 1ns/1ns

module vector_slot
  import clic_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  csr_wr_t   wr,
  input  logic      vec_we,
  input  logic      entry_we,
  input  logic      clear_pend,
  output slot_req_t req,
  output word       vec_val,
  output word       entry_val
);

  vec_store_t vec;
  entry_t     entry;
  entry_t     entry_cleared;

  // handler address, software only
  csr_reg #(
    .Width($bits(vec_store_t))
  ) u_vec (
    .clk,
    .arst_n,
    .we      (vec_we),
    .wr,
    .ext_we  (1'b0),
    .ext_data('0),
    .data    (vec),
    .value   (vec_val)
  );

  // acknowledge drops the pend bit and keeps the rest
  always_comb begin
    entry_cleared        = entry;
    entry_cleared.pended = 1'b0;
  end

  csr_reg #(
    .Width($bits(entry_t))
  ) u_entry (
    .clk,
    .arst_n,
    .we      (entry_we),
    .wr,
    .ext_we  (clear_pend),
    .ext_data(entry_cleared),
    .data    (entry),
    .value   (entry_val)
  );

  assign req = '{active: entry.enabled && entry.pended, prio: entry.prio, vec: vec};

endmodule

/* run.sh */
#!/bin/sh
# build and run the interrupt controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_n_clic -o sim_tb_n_clic
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb_n_clic)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

/* tests/tb_n_clic.sv */
// interrupt controller testbench
`timescale 1ns/1ns

module tb_n_clic
  import clic_pkg::*;
();

  localparam int VecSize    = 8;
  localparam int CycleLimit = 2000;

  typedef struct packed {
    int_action_t            act;
    imem_addr_t             addr;
    pc_interrupt_mux_t      sel;
    logic                   irq;
    logic [VecIdxWidth-1:0] idx;
    prio_t                  prio;
  } expect_t;

  logic              clk;
  logic              arst_n;
  logic              csr_enable;
  csr_addr_t         csr_addr;
  csr_op_t           csr_op;
  logic [4:0]        rs1_zimm;
  word               rs1_data;
  imem_addr_t        pc_in;
  word               csr_out;
  imem_addr_t        int_addr;
  pc_interrupt_mux_t pc_interrupt_sel;
  prio_t             level_out;
  logic              interrupt_out;

  // reference model of registers and return stack
  prio_t      m_thresh;
  vec_store_t m_vec [VecSize];
  entry_t     m_entry [VecSize];
  imem_addr_t m_stk_addr [$];
  prio_t      m_stk_prio [$];

  int word_errs;
  int addr_errs;
  int sel_errs;
  int prio_errs;
  int bit_errs;
  int other_errs;
  int cycles;
  int n_take;
  int n_tail;
  int n_ret;
  csr_op_t ops [6] = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};

  n_clic dut0 (
    .clk,
    .arst_n,
    .csr_enable,
    .csr_addr,
    .csr_op,
    .rs1_zimm,
    .rs1_data,
    .pc_in,
    .csr_out,
    .int_addr,
    .pc_interrupt_sel,
    .level_out,
    .interrupt_out
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("timeout after %0d cycles, the stimulus never finished", cycles);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // 0 unmapped, 1 threshold, 2 vector, 3 entry
  function automatic int csr_target(input csr_addr_t addr, output int idx);
    idx = 0;
    if (addr == MIntThreshAddr) begin
      return 1;
    end
    if (addr >= VecCsrBase && int'(addr) < int'(VecCsrBase) + VecSize) begin
      idx = int'(addr) - int'(VecCsrBase);
      return 2;
    end
    if (addr >= EntryCsrBase && int'(addr) < int'(EntryCsrBase) + VecSize) begin
      idx = int'(addr) - int'(EntryCsrBase);
      return 3;
    end
    return 0;
  endfunction

  function automatic word model_read(input csr_addr_t addr);
    int idx;
    int kind;
    kind = csr_target(addr, idx);
    case (kind)
      1:       return word'(m_thresh);
      2:       return word'(m_vec[idx]);
      3:       return word'(m_entry[idx]);
      default: return '0;
    endcase
  endfunction

  function automatic word apply_op(input csr_op_t op, input word cur, input word opnd);
    case (op)
      CSR_RS, CSR_RSI: return cur | opnd;
      CSR_RC, CSR_RCI: return cur & ~opnd;
      default:         return opnd;
    endcase
  endfunction

  function automatic expect_t expected_result(input imem_addr_t pc);
    expect_t r;
    logic    found;
    found  = 1'b0;
    r.act  = ACT_NONE;
    r.addr = pc;
    r.sel  = PC_NORMAL;
    r.irq  = 1'b0;
    r.idx  = '0;
    r.prio = m_thresh;
    // best enabled and pended vector at or above threshold with ties to the later index
    for (int k = 0; k < VecSize; k++) begin
      if (m_entry[k].enabled && m_entry[k].pended && m_entry[k].prio >= r.prio) begin
        found  = 1'b1;
        r.prio = m_entry[k].prio;
        r.idx  = VecIdxWidth'(k);
      end
    end
    if (found && r.prio > m_thresh) begin
      r.act = ACT_TAKE;
    end else if (pc == RetMarker && found) begin
      r.act = ACT_TAIL;
    end else if (pc == RetMarker) begin
      r.act = ACT_RETURN;
    end
    if (r.act == ACT_TAKE || r.act == ACT_TAIL) begin
      r.addr = {m_vec[r.idx], 2'b00};
      r.sel  = PC_INTERRUPT;
      r.irq  = 1'b1;
    end else if (r.act == ACT_RETURN) begin
      r.addr = (m_stk_addr.size() > 0) ? m_stk_addr[$] : '0;
      r.sel  = PC_INTERRUPT;
    end
    return r;
  endfunction

  // next state at the rising edge
  always @(posedge clk) begin : model_update
    expect_t e;
    entry_t  acked;
    prio_t   old_thresh;
    int      kind;
    int      idx;
    word     opnd;
    if (arst_n) begin
      e            = expected_result(pc_in);
      acked        = m_entry[e.idx];
      acked.pended = 1'b0;
      old_thresh   = m_thresh;
      if (csr_enable) begin
        opnd = (csr_op inside {CSR_RW, CSR_RS, CSR_RC}) ? rs1_data : word'(rs1_zimm);
        kind = csr_target(csr_addr, idx);
        case (kind)
          1:       m_thresh = prio_t'(apply_op(csr_op, word'(m_thresh), opnd));
          2:       m_vec[idx] = vec_store_t'(apply_op(csr_op, word'(m_vec[idx]), opnd));
          3:       m_entry[idx] = entry_t'(apply_op(csr_op, word'(m_entry[idx]), opnd));
          default: ;
        endcase
      end
      // controller writes override software in the same cycle
      case (e.act)
        ACT_TAKE: begin
          m_stk_addr.push_back(pc_in);
          m_stk_prio.push_back(old_thresh);
          m_thresh       = e.prio;
          m_entry[e.idx] = acked;
          n_take++;
        end
        ACT_TAIL: begin
          m_entry[e.idx] = acked;
          n_tail++;
        end
        ACT_RETURN: begin
          m_thresh = m_stk_prio.pop_back();
          void'(m_stk_addr.pop_back());
          n_ret++;
        end
        default: ;
      endcase
    end
  end

  task automatic check_word(input string what, input word got, input word exp);
    if (got !== exp) begin
      word_errs++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input string what, input imem_addr_t got, input imem_addr_t exp);
    if (got !== exp) begin
      addr_errs++;
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_sel(input string what, input pc_interrupt_mux_t got,
                           input pc_interrupt_mux_t exp);
    if (got !== exp) begin
      sel_errs++;
      $display("** Error at %0t ns: %s is %s, expected %s", $time, what, got.name(),
               exp.name());
    end
  endtask

  task automatic check_prio(input string what, input prio_t got, input prio_t exp);
    if (got !== exp) begin
      prio_errs++;
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      bit_errs++;
      $display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // inputs still hold last cycle's values here
  always @(negedge clk) begin : compare_outputs
    expect_t e;
    if (arst_n) begin
      e = expected_result(pc_in);
      check_word("csr_out", csr_out, model_read(csr_addr));
      check_addr("int_addr", int_addr, e.addr);
      check_sel("pc_interrupt_sel", pc_interrupt_sel, e.sel);
      check_prio("level_out", level_out, prio_t'(m_stk_addr.size()));
      check_bit("interrupt_out", interrupt_out, e.irq);
    end
  end

  // aligned so it never equals the return marker
  function automatic imem_addr_t normal_pc();
    return imem_addr_t'({$urandom, 2'b00});
  endfunction

  function automatic word entry_word(input prio_t p, input logic en, input logic pend);
    return word'(entry_t'{prio: p, enabled: en, pended: pend});
  endfunction

  function automatic csr_addr_t random_addr();
    case ($urandom % 5)
      0:       return MIntThreshAddr;
      1:       return VecCsrBase + csr_addr_t'($urandom % VecSize);
      2:       return EntryCsrBase + csr_addr_t'($urandom % VecSize);
      // unused offsets of the vector bank
      3:       return VecCsrBase + csr_addr_t'(VecSize + $urandom % (64 - VecSize));
      default: return csr_addr_t'($urandom);
    endcase
  endfunction

  task automatic drive(input logic en, input csr_op_t op, input csr_addr_t addr,
                       input word data, input imem_addr_t pc);
    word filler;
    filler = $urandom;
    @(negedge clk);
    csr_enable <= en;
    csr_op     <= op;
    csr_addr   <= addr;
    // the operand that op does not select carries unrelated bits
    if (op inside {CSR_RWI, CSR_RSI, CSR_RCI}) begin
      rs1_data <= filler;
      rs1_zimm <= data[4:0];
    end else begin
      rs1_data <= data;
      rs1_zimm <= filler[4:0];
    end
    pc_in      <= pc;
  endtask

  task automatic csr_write(input csr_op_t op, input csr_addr_t addr, input word data);
    drive(1'b1, op, addr, data, normal_pc());
  endtask

  task automatic idle(input csr_addr_t addr, input imem_addr_t pc);
    drive(1'b0, CSR_RW, addr, $urandom, pc);
  endtask

  initial begin : stimulus
    csr_op_t   op;
    csr_addr_t addr;
    word       data;
    int        idx;
    prio_t     p;
    int        total;
    void'($urandom(32'hde02_2645));
    word_errs  = 0;
    addr_errs  = 0;
    sel_errs   = 0;
    prio_errs  = 0;
    bit_errs   = 0;
    other_errs = 0;
    cycles     = 0;
    n_take     = 0;
    n_tail     = 0;
    n_ret      = 0;
    m_thresh   = '0;
    for (int k = 0; k < VecSize; k++) begin
      m_vec[k]   = '0;
      m_entry[k] = '0;
    end
    arst_n     = 1'b0;
    csr_enable = 1'b0;
    csr_addr   = '0;
    csr_op     = CSR_RW;
    rs1_zimm   = '0;
    rs1_data   = '0;
    pc_in      = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n <= 1'b1;

    // random csr traffic that never sets a pend bit
    repeat (200) begin
      op   = ops[$urandom % 6];
      addr = random_addr();
      data = $urandom;
      if (csr_target(addr, idx) == 3 && !(op inside {CSR_RC, CSR_RCI})) begin
        data[0] = 1'b0;
      end
      csr_write(op, addr, data);
      idle(addr, normal_pc());
    end

    // threshold at the top so pending vectors wait
    csr_write(CSR_RW, MIntThreshAddr, 32'd7);
    for (int k = 0; k < VecSize; k++) begin
      csr_write(CSR_RW, VecCsrBase + csr_addr_t'(k), $urandom);
      csr_write(CSR_RWI, EntryCsrBase + csr_addr_t'(k), '0);
    end
    repeat (10) idle(MIntThreshAddr, normal_pc());

    // pend every vector with two sharing the top priority
    for (int k = 0; k < VecSize; k++) begin
      p = prio_t'(1 + $urandom % 5);
      if (k == 3 || k == 6) begin
        p = 3'd6;
      end
      op = (k % 2 == 1) ? CSR_RWI : CSR_RW;
      csr_write(op, EntryCsrBase + csr_addr_t'(k), entry_word(p, 1'b1, 1'b1));
    end
    csr_write(CSR_RC, MIntThreshAddr, 32'd7);
    idle(MIntThreshAddr, normal_pc());
    idle(MIntThreshAddr, normal_pc());
    idle(EntryCsrBase + 6, normal_pc());

    // nested take and then an equal priority that must wait
    csr_write(CSR_RW, EntryCsrBase + 7, entry_word(3'd7, 1'b1, 1'b1));
    idle(MIntThreshAddr, normal_pc());
    idle(EntryCsrBase + 7, normal_pc());
    csr_write(CSR_RW, EntryCsrBase + 0, entry_word(3'd7, 1'b1, 1'b1));
    repeat (3) idle(MIntThreshAddr, normal_pc());

    // return marker while anything is stacked drains by tail chains and returns
    for (int i = 0; i < 40; i++) begin
      @(negedge clk);
      csr_enable <= 1'b0;
      csr_addr   <= (i % 2 == 0) ? MIntThreshAddr : EntryCsrBase + csr_addr_t'(i % VecSize);
      pc_in      <= (m_stk_prio.size() > 0) ? RetMarker : normal_pc();
    end
    idle(MIntThreshAddr, normal_pc());
    repeat (2) @(posedge clk);

    if (n_take == 0 || n_tail == 0 || n_ret == 0) begin
      other_errs++;
      $display("not every decision was seen: %0d takes, %0d tail chains, %0d returns",
               n_take, n_tail, n_ret);
    end
    total = word_errs + addr_errs + sel_errs + prio_errs + bit_errs + other_errs;
    $display("errors: csr_out %0d, int_addr %0d, sel %0d, level %0d, irq %0d, other %0d",
             word_errs, addr_errs, sel_errs, prio_errs, bit_errs, other_errs);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
logic/clic_pkg.sv
logic/csr_reg.sv
logic/csr_access.sv
logic/vector_slot.sv
logic/prio_select.sv
logic/ret_stack.sv
logic/clic_ctrl.sv
logic/n_clic.sv
tests/tb_n_clic.sv
